/* dv/gfxControllerTb.sv */
`timescale 1ns/100ps

module gfxControllerTb
	import gfxPkg::*;
();

	localparam int FbXBits   = 9;
	localparam int FbYBits   = 9;
	localparam int MemWords  = 1 << (FbXBits + FbYBits);
	// longest line near 1000 points at up to 4 cycles each plus a few thousand for the rest
	localparam int MaxCycles = 20000;

	logic        Clk;
	logic        rstN;
	wbReq_t      wbReq;
	wbRsp_t      wbRsp;
	fbReq_t      fbReq;
	fbWord_u     sramRd = '0;	// registered sram output into the DUT
	logic [15:0] mem [MemWords];	// sram contents
	logic [15:0] refMem [MemWords];	// expected contents
	bit          memFilled = 1'b0;
	int          cycles = 0;
	int          valueErrors = 0;
	int          otherErrors = 0;
	int          seedVal;

	gfxController #(.FbXBits(FbXBits), .FbYBits(FbYBits)) gfxController_i (
		.Clk(Clk), .i_rstN(rstN), .i_wb(wbReq), .i_fbRdData(sramRd),
		.o_wb(wbRsp), .o_fb(fbReq)
	);

	always #2 Clk = ~Clk;	// 4 ns period

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("run stopped after %0d cycles, the DUT never finished", MaxCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// sram model
	//////////////////////////////////////////////////

	function automatic logic [15:0] fillWord(input int a);
		logic [17:0] av;
		av = a;
		return av[15:0] ^ {av[17:16], 14'h2A5B};	// every address bit shows up
	endfunction

	always @(posedge Clk) begin
		if (!memFilled) begin
			for (int a = 0; a < MemWords; a++)
				mem[a] <= fillWord(a);
			memFilled <= 1'b1;
		end else if (fbReq.we) begin
			if (fbReq.byteEn[1]) mem[fbReq.addr][15:8] <= fbReq.data[15:8];	// upper lane
			if (fbReq.byteEn[0]) mem[fbReq.addr][7:0] <= fbReq.data[7:0];
		end
		sramRd.raw <= mem[fbReq.addr];	// data one edge after the address
	end

	//////////////////////////////////////////////////
	// pixel helpers
	//////////////////////////////////////////////////

	// row from y and column pair from x
	function automatic logic [FbXBits+FbYBits-1:0] pixAddr(input int x, input int y);
		logic [31:0] xv, yv;
		xv = x;
		yv = y;
		return {yv[FbYBits-1:0], xv[FbXBits:1]};
	endfunction

	function automatic pixel_t wordPixel(input logic [15:0] word, input int x);
		fbWord_u w;
		w.raw = word;
		return x[0] ? w.pix.loPix : w.pix.hiPix;	// even x is the upper byte
	endfunction

	function automatic pixel_t refPixel(input int x, input int y);
		return wordPixel(refMem[pixAddr(x, y)], x);
	endfunction

	task automatic refPlot(input int x, input int y, input pixel_t c);
		fbWord_u w;
		w.raw = refMem[pixAddr(x, y)];
		if (x[0])
			w.pix.loPix = c;
		else
			w.pix.hiPix = c;
		refMem[pixAddr(x, y)] = w.raw;
	endtask

	// inclusive run or just the start point when reversed
	task automatic refStraight(input int x1, input int y1, input int x2, input int y2,
			input bit vertical, input pixel_t c);
		int last;
		last = vertical ? y2 : x2;
		refPlot(x1, y1, c);
		for (int p = (vertical ? y1 : x1) + 1; p <= last; p++) begin
			if (vertical)
				refPlot(x1, p, c);
			else
				refPlot(p, y1, c);
		end
	endtask

	// integer bresenham including the end point
	task automatic refLine(input int x1, input int y1, input int x2, input int y2,
			input pixel_t c);
		int dx, dy, s1, s2, err, x, y, tmp;
		bit steep;
		dx = (x2 > x1) ? x2 - x1 : x1 - x2;
		dy = (y2 > y1) ? y2 - y1 : y1 - y2;
		s1 = (x2 > x1) ? 1 : ((x2 < x1) ? -1 : 0);
		s2 = (y2 > y1) ? 1 : ((y2 < y1) ? -1 : 0);
		steep = dy > dx;
		if (steep) begin
			tmp = dx;
			dx  = dy;
			dy  = tmp;
		end
		err = 2 * dy - dx;
		x = x1;
		y = y1;
		for (int i = 0; i <= dx; i++) begin
			refPlot(x, y, c);
			if (i == dx)
				break;	// no step after the last point
			while (err >= 0) begin
				if (steep)
					x += s1;
				else
					y += s2;
				err -= 2 * dx;
			end
			if (steep)
				y += s2;
			else
				x += s1;
			err += 2 * dy;
		end
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic checkPixel(input string name, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compareBox(input string name, input int xlo, input int xhi, input int ylo,
			input int yhi);
		for (int y = ylo; y <= yhi; y++)
			for (int x = xlo; x <= xhi; x++)
				if (wordPixel(mem[pixAddr(x, y)], x) !== refPixel(x, y))
					checkPixel($sformatf("%s x=%0d y=%0d", name, x, y), refPixel(x, y),
						wordPixel(mem[pixAddr(x, y)], x));
	endtask

	// bounding box of a line plus one pixel all round
	task automatic compareLineBox(input string name, input int x1, input int y1, input int x2,
			input int y2);
		compareBox(name, (x1 < x2 ? x1 : x2) - 1, (x1 > x2 ? x1 : x2) + 1,
			(y1 < y2 ? y1 : y2) - 1, (y1 > y2 ? y1 : y2) + 1);
	endtask

	//////////////////////////////////////////////////
	// wishbone master
	//////////////////////////////////////////////////

	task automatic wbCycle(input bit we, input regIdx_e idx, input logic [15:0] wdat,
			input logic [1:0] sel, output logic [15:0] rdat);
		int n;
		@(posedge Clk);
		#0.5;
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = we;
		wbReq.adr = idx;
		wbReq.sel = sel;
		wbReq.dat = wdat;
		n = 0;
		do begin
			@(posedge Clk);
			#0.5;
			n++;
		end while (!wbRsp.ack && n < 16);
		if (!wbRsp.ack) begin
			otherErrors++;
			$display("no ack from the DUT for register %0d", idx);
		end
		rdat = wbRsp.dat;	// valid while ack is high
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we  = 1'b0;
	endtask

	task automatic wbWrite(input regIdx_e idx, input logic [15:0] dat, input logic [1:0] sel);
		logic [15:0] unused;
		wbCycle(1'b1, idx, dat, sel, unused);
	endtask

	task automatic wbRead(input regIdx_e idx, output logic [15:0] dat);
		wbCycle(1'b0, idx, 16'h0000, 2'b11, dat);
	endtask

	task automatic waitIdle();
		logic [15:0] st;
		do
			wbRead(RegCmd, st);
		while (st[0] !== 1'b1);
	endtask

	task automatic drawJob(input cmd_e cmd, input int x1, input int y1, input int x2,
			input int y2, input pixel_t c);
		wbWrite(RegColour, {8'h00, c}, 2'b01);
		wbWrite(RegX1, 16'(x1), 2'b11);
		wbWrite(RegY1, 16'(y1), 2'b11);
		wbWrite(RegX2, 16'(x2), 2'b11);
		wbWrite(RegY2, 16'(y2), 2'b11);
		wbWrite(RegCmd, cmd, 2'b11);
		waitIdle();
	endtask

	task automatic readPixel(input int x, input int y, output pixel_t p);
		logic [15:0] d;
		wbWrite(RegX1, 16'(x), 2'b11);
		wbWrite(RegY1, 16'(y), 2'b11);
		wbWrite(RegCmd, GetPixel, 2'b11);
		waitIdle();
		wbRead(RegColour, d);
		p = d[7:0];
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic resetState();
		logic [15:0] d;
		checkWord("resetState", 16'h0000, {13'd0, wbRsp.ack, fbReq.we, |fbReq.byteEn});
		wbRead(RegCmd, d);
		checkWord("resetState", 16'h0001, d);
		wbWrite(RegX2, 16'h0123, 2'b11);
		wbRead(RegX2, d);
		checkWord("resetState", 16'h0123, d);
		wbWrite(RegY2, 16'hABCD, 2'b01);	// low lane only so the upper byte keeps 512
		wbRead(RegY2, d);
		checkWord("resetState", 16'h02CD, d);
		wbRead(RegCmd, d);
		checkWord("resetState", 16'h0001, d);
	endtask

	task automatic putPixel();
		drawJob(PutPixel, 100, 50, 120, 60, 8'h5A);	// x2/y2 ignored
		drawJob(PutPixel, 101, 50, 110, 55, 8'hC3);
		refPlot(100, 50, 8'h5A);
		refPlot(101, 50, 8'hC3);
		checkWord("putPixel", 16'h5AC3, mem[pixAddr(100, 50)]);
		compareBox("putPixel", 98, 103, 49, 51);
	endtask

	task automatic straightLines();
		drawJob(HLine, 200, 20, 215, 99, 8'h11);
		refStraight(200, 20, 215, 99, 1'b0, 8'h11);
		compareBox("straightLines", 198, 217, 19, 21);
		drawJob(VLine, 300, 30, 7, 45, 8'h22);
		refStraight(300, 30, 7, 45, 1'b1, 8'h22);
		compareBox("straightLines", 299, 301, 28, 47);
		drawJob(HLine, 260, 60, 250, 60, 8'h33);	// reversed run draws its start point only
		refStraight(260, 60, 250, 60, 1'b0, 8'h33);
		compareBox("straightLines", 248, 262, 59, 61);
	endtask

	task automatic bresenhamLines();
		int major, minor, ddx, ddy, x2, y2;
		pixel_t c;
		for (int oct = 0; oct < 8; oct++) begin
			major = int'($urandom % 100) + 1;
			minor = int'($urandom % (major + 1));
			if (oct[0]) begin	// steep octants
				ddx = minor;
				ddy = major;
			end else begin
				ddx = major;
				ddy = minor;
			end
			if (oct[1]) ddx = -ddx;
			if (oct[2]) ddy = -ddy;
			x2 = 512 + ddx;
			y2 = 256 + ddy;
			c  = pixel_t'(8'h40 + oct);
			drawJob(ALine, 512, 256, x2, y2, c);
			refLine(512, 256, x2, y2, c);
			compareLineBox("bresenhamLines", 512, 256, x2, y2);
		end
		drawJob(ALine, 600, 100, 600, 100, 8'h7E);	// zero length draws one pixel
		refLine(600, 100, 600, 100, 8'h7E);
		compareLineBox("bresenhamLines", 600, 100, 600, 100);
	endtask

	task automatic getPixel();
		pixel_t p;
		readPixel(100, 50, p);
		checkPixel("getPixel", refPixel(100, 50), p);
		readPixel(101, 50, p);
		checkPixel("getPixel", refPixel(101, 50), p);
		readPixel(215, 20, p);	// odd x at the end of the hline
		checkPixel("getPixel", refPixel(215, 20), p);
		readPixel(512, 256, p);
		checkPixel("getPixel", refPixel(512, 256), p);
	endtask

	task automatic busyDrop();
		logic [15:0] d;
		wbWrite(RegColour, 16'h0099, 2'b01);
		wbWrite(RegX1, 16'd10, 2'b11);
		wbWrite(RegY1, 16'd300, 2'b11);
		wbWrite(RegX2, 16'd1010, 2'b11);
		wbWrite(RegY2, 16'd340, 2'b11);
		wbWrite(RegCmd, ALine, 2'b11);
		wbRead(RegCmd, d);
		checkWord("busyDrop", 16'h0000, d);	// busy right after start
		wbWrite(RegX1, 16'd20, 2'b11);	// walker already holds its job
		wbWrite(RegY1, 16'd400, 2'b11);
		wbWrite(RegCmd, PutPixel, 2'b11);	// dropped while busy
		waitIdle();
		refLine(10, 300, 1010, 340, 8'h99);
		compareLineBox("busyDrop", 10, 300, 1010, 340);
		compareBox("busyDrop", 18, 22, 398, 402);
	endtask

	initial begin
		seedVal = $urandom(91683);
		Clk   = 1'b0;
		rstN  = 1'b0;
		wbReq = '0;
		for (int a = 0; a < MemWords; a++)
			refMem[a] = fillWord(a);
		repeat (8) @(posedge Clk);
		#0.5;
		rstN = 1'b1;

		resetState();
		putPixel();
		straightLines();
		bresenhamLines();
		getPixel();
		busyDrop();

		$display("%0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* rtl/bresenhamWalker.sv */
`timescale 1ns/100ps

module bresenhamWalker
	import gfxPkg::*;
(
	input  logic      Clk,
	input  logic      i_rstN,
	input  cmdStart_t i_start,
	input  lineJob_t  i_job,
	output plot_t     o_plot,
	output logic      o_active
);

	// Setup doubles as the idle state
	typedef enum logic [2:0] {
		Setup,
		Swap,
		ErrInit,
		Plot,
		StepMinor,
		StepMajor
	} bresState_e;

	bresState_e         state;
	coord_t             x, y;	// current point
	coord_t             s1, s2;	// x and y step, -1 0 or +1
	logic [15:0]        dx, dy;	// major and minor lengths after the swap
	logic signed [17:0] err;
	logic               interchange;	// y is the major axis
	logic [15:0]        cnt;	// points done minus one
	logic signed [16:0] diffX, diffY;

	function automatic logic [15:0] absDiff(input logic signed [16:0] d);
		logic signed [16:0] a;
		a = (d < 0) ? -d : d;
		return a[15:0];
	endfunction

	function automatic coord_t stepSign(input logic signed [16:0] d);
		if (d < 0)
			return -16'sd1;
		else if (d == 0)
			return 16'sd0;
		else
			return 16'sd1;
	endfunction

	assign diffX = i_job.x2 - i_job.x1;	// 17 bits, no overflow
	assign diffY = i_job.y2 - i_job.y1;

	//////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!i_rstN) begin
			state <= Setup;
		end else begin
			case (state)
				Setup:     if (i_start.bresenham) state <= Swap;
				Swap:      state <= ErrInit;
				ErrInit:   state <= Plot;
				Plot:      state <= (cnt == dx) ? Setup : StepMinor;	// dx+1 points, end included
				StepMinor: if (err < 0) state <= StepMajor;	// loop while err >= 0
				StepMajor: state <= Plot;
				default:   state <= Setup;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		case (state)
			Setup: if (i_start.bresenham) begin
				x  <= i_job.x1;
				y  <= i_job.y1;
				dx <= absDiff(diffX);
				dy <= absDiff(diffY);
				s1 <= stepSign(diffX);
				s2 <= stepSign(diffY);
			end
			Swap: begin
				interchange <= (dy > dx);
				if (dy > dx) begin	// steep line, walk along y
					dx <= dy;
					dy <= dx;
				end
			end
			ErrInit: begin
				err <= $signed({1'b0, dy, 1'b0}) - $signed({2'b00, dx});	// 2dy - dx
				cnt <= '0;
			end
			StepMinor: if (err >= 0) begin
				if (interchange)
					x <= x + s1;
				else
					y <= y + s2;
				err <= err - $signed({1'b0, dx, 1'b0});
			end
			StepMajor: begin
				if (interchange)
					y <= y + s2;
				else
					x <= x + s1;
				err <= err + $signed({1'b0, dy, 1'b0});
				cnt <= cnt + 16'd1;
			end
			default: ;	// Plot only emits
		endcase
	end

	assign o_plot.valid = (state == Plot);
	assign o_plot.x     = x;
	assign o_plot.y     = y;
	assign o_active     = (state != Setup);

endmodule

/* rtl/fbPort.sv */
`timescale 1ns/100ps

module fbPort
	import gfxPkg::*;
#(
	parameter int FbXBits = 9,
	parameter int FbYBits = 9
) (
	input  logic      Clk,
	input  logic      i_rstN,
	input  cmdStart_t i_start,
	input  lineJob_t  i_job,
	input  pixel_t    i_colour,
	input  plot_t     i_straightPlot,
	input  plot_t     i_bresPlot,
	input  logic      i_straightActive,
	input  logic      i_bresActive,
	input  fbWord_u   i_fbRdData,	// registered sram output
	output fbReq_t    o_fb,
	output pixel_t    o_pixel,
	output logic      o_busy
);

	plot_t       plot;	// point from whichever walker runs
	fbWord_u     wrWord;
	logic        fbWe;
	logic [1:0]  fbByteEn;
	logic [17:0] fbAddr;
	logic [15:0] fbData;
	logic        rdIssued;	// read request on the sram pins
	logic        rdReturn;	// sram data valid
	logic        rdHi;	// even x, take the upper byte
	logic        busyQ;

	// row from y and column pair from x while x[0] picks the byte
	function automatic logic [17:0] wordAddr(input coord_t x, input coord_t y);
		return {y[FbYBits-1:0], x[FbXBits:1]};
	endfunction

	assign plot = i_straightActive ? i_straightPlot : i_bresPlot;

	always_comb begin
		wrWord.pix.hiPix = i_colour;	// same colour in both lanes
		wrWord.pix.loPix = i_colour;	// byteEn picks which one lands
	end

	//////////////////////////////////////////////////
	// sram control and busy
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!i_rstN) begin
			fbWe     <= 1'b0;
			fbByteEn <= 2'b00;
			rdIssued <= 1'b0;
			rdReturn <= 1'b0;
			busyQ    <= 1'b0;
		end else begin
			rdIssued <= i_start.readPix;
			rdReturn <= rdIssued;	// sram answers one edge later
			busyQ    <= (|i_start) | i_straightActive | i_bresActive | fbWe | rdIssued | rdReturn;
			if (i_start.readPix) begin
				fbWe     <= 1'b0;
				fbByteEn <= 2'b11;	// read the whole word
			end else if (plot.valid) begin
				fbWe     <= 1'b1;
				fbByteEn <= plot.x[0] ? 2'b01 : 2'b10;	// even x is upper
			end else begin
				fbWe     <= 1'b0;
				fbByteEn <= 2'b00;
			end
		end
	end

	// address, data and the read byte
	always_ff @(posedge Clk) begin
		if (i_start.readPix) begin
			fbAddr <= wordAddr(i_job.x1, i_job.y1);
			rdHi   <= ~i_job.x1[0];
		end else if (plot.valid) begin
			fbAddr <= wordAddr(plot.x, plot.y);
			fbData <= wrWord.raw;
		end
		if (rdReturn)
			o_pixel <= rdHi ? i_fbRdData.pix.hiPix : i_fbRdData.pix.loPix;
	end

	assign o_fb.addr   = fbAddr;
	assign o_fb.data   = fbData;
	assign o_fb.we     = fbWe;
	assign o_fb.byteEn = fbByteEn;
	assign o_busy      = busyQ;

endmodule

/* rtl/gfxController.sv */
`timescale 1ns/100ps

module gfxController
	import gfxPkg::*;
#(
	parameter int FbXBits = 9,
	parameter int FbYBits = 9
) (
	input  logic    Clk,
	input  logic    i_rstN,
	input  wbReq_t  i_wb,
	input  fbWord_u i_fbRdData,
	output wbRsp_t  o_wb,
	output fbReq_t  o_fb
);

	cmdStart_t start;
	lineJob_t  job;
	pixel_t    colour;
	pixel_t    pixel;	// GetPixel result
	logic      busy;
	plot_t     straightPlot, bresPlot;
	logic      straightActive, bresActive;

	gfxRegs gfxRegs_i (
		.Clk(Clk), .i_rstN(i_rstN), .i_wb(i_wb), .i_busy(busy), .i_pixel(pixel),
		.o_wb(o_wb), .o_start(start), .o_job(job), .o_colour(colour)
	);

	// horizontal, vertical and single pixel runs
	straightWalker straightWalker_i (
		.Clk(Clk), .i_rstN(i_rstN), .i_start(start), .i_job(job),
		.o_plot(straightPlot), .o_active(straightActive)
	);

	bresenhamWalker bresenhamWalker_i (
		.Clk(Clk), .i_rstN(i_rstN), .i_start(start), .i_job(job),
		.o_plot(bresPlot), .o_active(bresActive)
	);

	fbPort #(.FbXBits(FbXBits), .FbYBits(FbYBits)) fbPort_i (
		.Clk(Clk), .i_rstN(i_rstN), .i_start(start), .i_job(job), .i_colour(colour),
		.i_straightPlot(straightPlot), .i_bresPlot(bresPlot),
		.i_straightActive(straightActive), .i_bresActive(bresActive),
		.i_fbRdData(i_fbRdData), .o_fb(o_fb), .o_pixel(pixel), .o_busy(busy)
	);

endmodule

/* rtl/gfxPkg.sv */
package gfxPkg;

	//////////////////////////////////////////////////
	// pixel and coordinate types
	//////////////////////////////////////////////////

	typedef logic signed [15:0] coord_t;	// signed so a reversed run compares right
	typedef logic [7:0] pixel_t;	// palette index, one byte per pixel

	// opcodes written to the command register
	typedef enum logic [15:0] {
		HLine    = 16'h0001,
		VLine    = 16'h0002,
		ALine    = 16'h0003,	// any line, bresenham
		PutPixel = 16'h000A,
		GetPixel = 16'h000B
	} cmd_e;

	// word index on the wishbone adr field
	typedef enum logic [3:0] {
		RegCmd    = 4'd0,	// command on write, status on read
		RegX1     = 4'd1,
		RegY1     = 4'd2,
		RegX2     = 4'd3,
		RegY2     = 4'd4,
		RegColour = 4'd7
	} regIdx_e;

	//////////////////////////////////////////////////
	// wishbone classic
	//////////////////////////////////////////////////

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;	// word index, not a byte address
		logic [1:0]  sel;	// [1] upper byte, [0] lower byte
		logic [15:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic        ack;	// one cycle per request
		logic [15:0] dat;
	} wbRsp_t;

	//////////////////////////////////////////////////
	// drawing jobs and frame buffer
	//////////////////////////////////////////////////

	typedef struct packed {
		coord_t x1;
		coord_t y1;
		coord_t x2;
		coord_t y2;
	} lineJob_t;

	// single cycle strobes out of the command dispatch
	typedef struct packed {
		logic straight;
		logic vertical;	// qualifies straight
		logic bresenham;
		logic readPix;
	} cmdStart_t;

	typedef struct packed {
		logic   valid;
		coord_t x;
		coord_t y;
	} plot_t;

	typedef struct packed {
		logic [17:0] addr;	// {row, column pair}
		logic [15:0] data;
		logic        we;	// low for a read
		logic [1:0]  byteEn;	// active high, upper then lower
	} fbReq_t;

	// one sram word, two pixels side by side
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			pixel_t hiPix;	// even x
			pixel_t loPix;	// odd x
		} pix;
	} fbWord_u;

endpackage

/* rtl/gfxRegs.sv */
`timescale 1ns/100ps

module gfxRegs
	import gfxPkg::*;
(
	input  logic      Clk,
	input  logic      i_rstN,
	input  wbReq_t    i_wb,
	input  logic      i_busy,	// from fbPort
	input  pixel_t    i_pixel,	// last pixel read back
	output wbRsp_t    o_wb,
	output cmdStart_t o_start,
	output lineJob_t  o_job,
	output pixel_t    o_colour
);

	coord_t      x1, y1, x2, y2;
	pixel_t      colour;	// only the low byte of the colour word is kept
	logic [15:0] cmdReg;
	logic [15:0] cmdNext;	// command word with this write's lanes applied
	logic        ackQ;
	logic [15:0] rdDat, rdDatQ;
	logic        access;	// fresh request, not the one being acked
	logic        wrAccess;

	// byte lane merge, sel[1] is the upper byte
	function automatic logic [15:0] laneMerge(input logic [15:0] old, input logic [15:0] dat,
			input logic [1:0] sel);
		logic [15:0] res;
		res = old;
		if (sel[1])
			res[15:8] = dat[15:8];
		if (sel[0])
			res[7:0] = dat[7:0];
		return res;
	endfunction

	assign access   = i_wb.cyc & i_wb.stb & ~ackQ;	// master holds stb through ack
	assign wrAccess = access & i_wb.we;
	assign cmdNext  = laneMerge(cmdReg, i_wb.dat, i_wb.sel);

	//////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!i_rstN) begin
			x1     <= '0;
			y1     <= '0;
			x2     <= 16'sd1024;	// full screen width
			y2     <= 16'sd512;
			colour <= 8'd4;
			cmdReg <= '0;
		end else if (wrAccess) begin
			case (i_wb.adr)
				RegCmd:    cmdReg <= cmdNext;	// stored even when busy
				RegX1:     x1 <= laneMerge(x1, i_wb.dat, i_wb.sel);
				RegY1:     y1 <= laneMerge(y1, i_wb.dat, i_wb.sel);
				RegX2:     x2 <= laneMerge(x2, i_wb.dat, i_wb.sel);
				RegY2:     y2 <= laneMerge(y2, i_wb.dat, i_wb.sel);
				RegColour: if (i_wb.sel[0]) colour <= i_wb.dat[7:0];
				default: ;	// unmapped, write ignored
			endcase
		end
	end

	//////////////////////////////////////////////////
	// ack and command dispatch
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!i_rstN) begin
			ackQ    <= 1'b0;
			o_start <= '0;
		end else begin
			ackQ    <= access;
			o_start <= '0;	// strobes last one cycle, same cycle as ack
			if (wrAccess && i_wb.adr == RegCmd && !i_busy) begin
				case (cmdNext)
					HLine, PutPixel: o_start.straight <= 1'b1;	// pixel is a 1 point run
					VLine: begin
						o_start.straight <= 1'b1;
						o_start.vertical <= 1'b1;
					end
					ALine:    o_start.bresenham <= 1'b1;
					GetPixel: o_start.readPix   <= 1'b1;
					default: ;	// unknown opcode starts nothing
				endcase
			end
		end
	end

	// read mux, status bit 0 is idle
	always_comb begin
		case (i_wb.adr)
			RegCmd:    rdDat = {15'd0, ~i_busy};
			RegX1:     rdDat = x1;
			RegY1:     rdDat = y1;
			RegX2:     rdDat = x2;
			RegY2:     rdDat = y2;
			RegColour: rdDat = {8'd0, i_pixel};	// pixel latched by GetPixel
			default:   rdDat = '0;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (access)
			rdDatQ <= rdDat;
	end

	assign o_wb.ack = ackQ;
	assign o_wb.dat = rdDatQ;	// valid while ack is high

	// PutPixel ends where it starts
	assign o_job.x1 = x1;
	assign o_job.y1 = y1;
	assign o_job.x2 = (cmdReg == PutPixel) ? x1 : x2;
	assign o_job.y2 = (cmdReg == PutPixel) ? y1 : y2;

	assign o_colour = colour;

endmodule

/* rtl/straightWalker.sv */
`timescale 1ns/100ps

module straightWalker
	import gfxPkg::*;
(
	input  logic      Clk,
	input  logic      i_rstN,
	input  cmdStart_t i_start,
	input  lineJob_t  i_job,
	output plot_t     o_plot,
	output logic      o_active
);

	logic   active;
	logic   vertical;	// walk y instead of x
	coord_t curX, curY;
	coord_t endPos;	// last coordinate on the walking axis
	coord_t runPos;

	assign runPos = vertical ? curY : curX;

	// one point per cycle, stop once the end is reached or passed
	always_ff @(posedge Clk) begin
		if (!i_rstN)
			active <= 1'b0;
		else if (i_start.straight)
			active <= 1'b1;
		else if (active && runPos >= endPos)
			active <= 1'b0;	// reversed run stops after its start point
	end

	always_ff @(posedge Clk) begin
		if (i_start.straight) begin
			curX     <= i_job.x1;
			curY     <= i_job.y1;
			vertical <= i_start.vertical;
			endPos   <= i_start.vertical ? i_job.y2 : i_job.x2;
		end else if (active && runPos < endPos) begin
			if (vertical)
				curY <= curY + 16'sd1;
			else
				curX <= curX + 16'sd1;
		end
	end

	assign o_plot.valid = active;	// current point goes out every active cycle
	assign o_plot.x     = curX;
	assign o_plot.y     = curY;
	assign o_active     = active;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module gfxControllerTb -o simv
./obj_dir/simv | tee sim.log

if grep -q "Testbench passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* tb.f */
rtl/gfxPkg.sv
rtl/gfxRegs.sv
rtl/straightWalker.sv
rtl/bresenhamWalker.sv
rtl/fbPort.sv
rtl/gfxController.sv
dv/gfxControllerTb.sv
